/* filelist.f */
+incdir+source
source/kbd_pkg.sv
source/ps2_receiver.sv
source/scancode_map.sv
source/keyboard_ctrl.sv
source/key_matrix.sv
source/ti_keyboard_top.sv
tests/ti_keyboard_asserts.sv
tests/ti_keyboard_tb.sv

/* tests/ti_keyboard_tb.sv */
`include "kbd_config.svh"

module ti_keyboard_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_ROWS = 128;

   logic                clk;
   logic                reset_i;
   logic                ps2_clk_i;
   logic                ps2_dat_i;
   kbd_pkg::key_state_t key_state;
   logic                alpha_lock;
   logic                keypress;
   kbd_pkg::keycode_t   keycode;
   logic                isup;
   logic                frame_err;

   // One stimulus row per key event
   logic [7:0]          row_bytes [MAX_ROWS][3];
   int                  row_len [MAX_ROWS];
   int                  row_corrupt [MAX_ROWS];   // 1 parity, 2 stop, 3 cut after 5 bits
   logic                row_press [MAX_ROWS];
   int                  row_code [MAX_ROWS];
   logic                row_up [MAX_ROWS];
   kbd_pkg::key_state_t row_state [MAX_ROWS];
   logic                row_alpha [MAX_ROWS];
   int                  num_rows;

   kbd_pkg::key_state_t model_state;
   logic                model_alpha;

   int   errors;
   int   timeouts;
   int   press_count;
   int   err_pulses;
   int   last_code;
   logic last_up;
   int   r;
   int   pick [3];

   logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
                                     8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                     8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C,
                                     8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
   logic [7:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                    8'h3D, 8'h3E, 8'h46};
   // Space, enter, equals, slash, comma, period, shifts, ctrl, alt
   logic [7:0] misc_codes [10] = '{8'h29, 8'h5A, 8'h55, 8'h4A, 8'h41, 8'h49, 8'h12,
                                   8'h59, 8'h14, 8'h11};
   int         misc_keys [10]  = '{36, 37, 38, 39, 43, 44, 40, 40, 41, 42};
   // Up, left, right, down
   logic [7:0] arrow_codes [4] = '{8'h75, 8'h6B, 8'h74, 8'h72};
   int         arrow_keys [4]  = '{4, 18, 3, 23};

   ti_keyboard_top DUT (
      .clk(clk), .reset_i(reset_i),
      .ps2_clk_i(ps2_clk_i), .ps2_dat_i(ps2_dat_i),
      .key_state_o(key_state), .alpha_lock_o(alpha_lock),
      .keypress_o(keypress), .keycode_o(keycode), .isup_o(isup),
      .frame_err_o(frame_err)
   );

   always #5 clk = ~clk;

   // Event capture away from the active edge
   always @(negedge clk) begin
      if (keypress) begin
         press_count++;
         last_code = int'(keycode);
         last_up   = isup;
      end
      if (frame_err)
         err_pulses++;
   end

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                  expected);
      end
   endtask

   // Expected matrix follows each row as it is added
   task automatic add_row(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
                          input int len, input int corrupt, input logic press,
                          input int code, input logic up);
      row_bytes[num_rows][0] = b0;
      row_bytes[num_rows][1] = b1;
      row_bytes[num_rows][2] = b2;
      row_len[num_rows]      = len;
      row_corrupt[num_rows]  = corrupt;
      row_press[num_rows]    = press;
      row_code[num_rows]     = code;
      row_up[num_rows]       = up;
      if (press) begin
         if (code == `KBD_ALPHA_CODE) begin
            if (!up)
               model_alpha = !model_alpha;
         end else begin
            model_state[code] = !up;
         end
      end
      row_state[num_rows] = model_state;
      row_alpha[num_rows] = model_alpha;
      num_rows++;
   endtask

   task automatic press_row(input logic [7:0] code, input logic ext, input int key);
      if (ext)
         add_row(8'hE0, code, 8'h00, 2, 0, 1'b1, key, 1'b0);
      else
         add_row(code, 8'h00, 8'h00, 1, 0, 1'b1, key, 1'b0);
   endtask

   task automatic release_row(input logic [7:0] code, input logic ext, input int key);
      if (ext)
         add_row(8'hE0, 8'hF0, code, 3, 0, 1'b1, key, 1'b1);
      else
         add_row(8'hF0, code, 8'h00, 2, 0, 1'b1, key, 1'b1);
   endtask

   task automatic build_table();
      int i;
      for (i = 0; i < 26; i++) begin
         press_row(letter_codes[i], 1'b0, i);
         release_row(letter_codes[i], 1'b0, i);
      end
      for (i = 0; i < 10; i++) begin
         press_row(digit_codes[i], 1'b0, 26 + i);
         release_row(digit_codes[i], 1'b0, 26 + i);
      end
      for (i = 0; i < 10; i++) begin
         press_row(misc_codes[i], 1'b0, misc_keys[i]);
         release_row(misc_codes[i], 1'b0, misc_keys[i]);
      end
      for (i = 0; i < 4; i++) begin
         press_row(arrow_codes[i], 1'b1, arrow_keys[i]);
         release_row(arrow_codes[i], 1'b1, arrow_keys[i]);
      end
      // Extended unmapped code followed by a plain A that must decode
      add_row(8'hE0, 8'h1C, 8'h00, 2, 0, 1'b0, 0, 1'b0);
      press_row(8'h1C, 1'b0, 0);
      release_row(8'h1C, 1'b0, 0);
      // Three distinct random letters held with shift
      pick[0] = $urandom % 26;
      pick[1] = (pick[0] + 1 + $urandom % 12) % 26;
      pick[2] = (pick[1] + 1 + $urandom % 12) % 26;
      press_row(8'h12, 1'b0, 40);
      for (i = 0; i < 3; i++)
         press_row(letter_codes[pick[i]], 1'b0, pick[i]);
      release_row(letter_codes[pick[1]], 1'b0, pick[1]);
      release_row(letter_codes[pick[0]], 1'b0, pick[0]);
      release_row(letter_codes[pick[2]], 1'b0, pick[2]);
      release_row(8'h12, 1'b0, 40);
      for (i = 0; i < 2; i++) begin
         press_row(8'h58, 1'b0, `KBD_ALPHA_CODE);
         release_row(8'h58, 1'b0, `KBD_ALPHA_CODE);
      end
      add_row(8'h1C, 8'h00, 8'h00, 1, 1, 1'b0, 0, 1'b0);
      add_row(8'h1C, 8'h00, 8'h00, 1, 2, 1'b0, 0, 1'b0);
      add_row(8'h1C, 8'h00, 8'h00, 1, 3, 1'b0, 0, 1'b0);
      press_row(8'h1C, 1'b0, 0);
      release_row(8'h1C, 1'b0, 0);
      add_row(8'h05, 8'h00, 8'h00, 1, 0, 1'b0, 0, 1'b0);   // F1 has no slot
   endtask

   // PS/2 clock runs at 40 cycles per half period
   task automatic send_frame(input logic [7:0] data, input int corrupt);
      logic [10:0] bits;
      int          nbits;
      int          i;
      bits  = {1'b1, ~^data, data, 1'b0};
      nbits = 11;
      if (corrupt == 1)
         bits[9] = ~bits[9];
      else if (corrupt == 2)
         bits[10] = 1'b0;
      else if (corrupt == 3)
         nbits = 5;
      @(negedge clk);
      for (i = 0; i < nbits; i++) begin
         ps2_dat_i = bits[i];
         repeat (20) @(negedge clk);
         ps2_clk_i = 1'b0;
         repeat (40) @(negedge clk);
         ps2_clk_i = 1'b1;
         repeat (20) @(negedge clk);
      end
      ps2_dat_i = 1'b1;
   endtask

   task automatic wait_for_keypress(input int base);
      int cycles;
      cycles = 0;
      while (press_count == base && cycles < 400) begin
         @(posedge clk);
         cycles++;
      end
      if (press_count == base) begin
         timeouts++;
         $display("Timeout at %0t ns: no keypress came after the frame", $time);
      end
   endtask

   task automatic wait_for_frame_err(input int base);
      int cycles;
      cycles = 0;
      while (err_pulses == base && cycles < 3000) begin
         @(posedge clk);
         cycles++;
      end
      if (err_pulses == base) begin
         timeouts++;
         $display("Timeout at %0t ns: the bad frame was never flagged", $time);
      end
   endtask

   task automatic apply_row(input int idx);
      int press_base;
      int err_base;
      int b;
      press_base = press_count;
      err_base   = err_pulses;
      for (b = 0; b < row_len[idx]; b++) begin
         send_frame(row_bytes[idx][b], (b == row_len[idx] - 1) ? row_corrupt[idx] : 0);
         repeat (10 + $urandom % 50) @(negedge clk);
      end
      if (row_press[idx])
         wait_for_keypress(press_base);
      if (row_corrupt[idx] != 0)
         wait_for_frame_err(err_base);
      repeat (2) @(negedge clk);   // Matrix settles one cycle after the strobe
      check_value(press_count - press_base, row_press[idx],
                  $sformatf("row %0d keypress count", idx));
      check_value(err_pulses - err_base, row_corrupt[idx] != 0,
                  $sformatf("row %0d frame error count", idx));
      if (row_press[idx] && press_count != press_base) begin
         check_value(last_code, row_code[idx], $sformatf("row %0d keycode", idx));
         check_value(last_up, row_up[idx], $sformatf("row %0d isup", idx));
      end
      check_value(key_state, row_state[idx], $sformatf("row %0d key_state", idx));
      check_value(alpha_lock, row_alpha[idx], $sformatf("row %0d alpha_lock", idx));
   endtask

   initial begin
      clk         = 1'b0;
      reset_i     = 1'b1;
      ps2_clk_i   = 1'b1;   // Idle bus
      ps2_dat_i   = 1'b1;
      errors      = 0;
      timeouts    = 0;
      press_count = 0;
      err_pulses  = 0;
      num_rows    = 0;
      model_state = '0;
      model_alpha = 1'b0;
      void'($urandom(32'h55e6ba58));
      build_table();

      repeat (3) @(negedge clk);
      reset_i = 1'b0;
      @(negedge clk);
      check_value(key_state, '0, "key_state after reset");
      check_value(alpha_lock, 1'b0, "alpha_lock after reset");
      check_value(keypress, 1'b0, "keypress after reset");
      check_value(frame_err, 1'b0, "frame_err after reset");

      for (r = 0; r < num_rows; r++)
         apply_row(r);

      $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* tests/ti_keyboard_asserts.sv */
module ti_keyboard_asserts (
   input logic                clk,
   input logic                reset_i,
   input logic                recv_trigger_i,
   input logic                frame_err_i,
   input logic                keypress_i,
   input kbd_pkg::key_state_t key_state_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // Event strobe is a single cycle wide
   keypress_single: assert property (@(posedge clk) disable iff (reset_i)
      keypress_i |=> !keypress_i)
      else $error("keypress held high for two cycles");

   // A frame is either good or bad, never both
   frame_exclusive: assert property (@(posedge clk) disable iff (reset_i)
      !(recv_trigger_i && frame_err_i))
      else $error("recv_trigger and frame_err high together");

   keypress_after_trigger: assert property (@(posedge clk) disable iff (reset_i)
      keypress_i |-> $past(recv_trigger_i))
      else $error("keypress without a trigger one cycle earlier");

   // Matrix comes out of reset empty
   matrix_cleared: assert property (@(posedge clk)
      $past(reset_i) |-> (key_state_i == '0))
      else $error("key_state not zero after reset");

endmodule

bind ti_keyboard_top ti_keyboard_asserts bound_checks (
   .clk(clk),
   .reset_i(reset_i),
   .recv_trigger_i(recv_trigger),
   .frame_err_i(frame_err_o),
   .keypress_i(keypress_o),
   .key_state_i(key_state_o)
);

/* source/ti_keyboard_top.sv */
module ti_keyboard_top (
   input  logic                clk,
   input  logic                reset_i,
   input  logic                ps2_clk_i,
   input  logic                ps2_dat_i,
   output kbd_pkg::key_state_t key_state_o,
   output logic                alpha_lock_o,
   output logic                keypress_o,
   output kbd_pkg::keycode_t   keycode_o,
   output logic                isup_o,
   output logic                frame_err_o
);

   kbd_pkg::scancode_t recv_byte;
   logic               recv_trigger;
   kbd_pkg::scancode_t map_code;
   logic               map_ext;
   kbd_pkg::keycode_t  map_keycode;
   logic               map_valid;

   ps2_receiver rx (
      .clk(clk), .reset_i(reset_i),
      .ps2_clk_i(ps2_clk_i), .ps2_dat_i(ps2_dat_i),
      .recv_byte_o(recv_byte), .recv_trigger_o(recv_trigger),
      .frame_err_o(frame_err_o)
   );

   keyboard_ctrl ctrl (
      .clk(clk), .reset_i(reset_i),
      .recv_byte_i(recv_byte), .recv_trigger_i(recv_trigger),
      .map_code_o(map_code), .map_ext_o(map_ext),
      .map_keycode_i(map_keycode), .map_valid_i(map_valid),
      .keypress_o(keypress_o), .keycode_o(keycode_o), .isup_o(isup_o)
   );

   // Same cycle lookup for the control FSM
   scancode_map keymap (
      .code_i(map_code), .ext_i(map_ext),
      .keycode_o(map_keycode), .valid_o(map_valid)
   );

   // Matrix follows the same event strobe that leaves the block
   key_matrix matrix (
      .clk(clk), .reset_i(reset_i),
      .keypress_i(keypress_o), .keycode_i(keycode_o), .isup_i(isup_o),
      .key_state_o(key_state_o), .alpha_lock_o(alpha_lock_o)
   );

endmodule

/* source/key_matrix.sv */
`include "kbd_config.svh"

module key_matrix (
   input  logic                clk,
   input  logic                reset_i,
   input  logic                keypress_i,
   input  kbd_pkg::keycode_t   keycode_i,
   input  logic                isup_i,
   output kbd_pkg::key_state_t key_state_o,
   output logic                alpha_lock_o
);

   logic is_alpha;
   logic in_range;

   assign is_alpha = (keycode_i == kbd_pkg::keycode_t'(`KBD_ALPHA_CODE));
   assign in_range = (keycode_i < `KBD_NUM_KEYS);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         key_state_o  <= '0;
         alpha_lock_o <= 1'b0;
      end else if (keypress_i) begin
         if (is_alpha) begin
            // Caps Lock latches on each make, release is ignored
            if (!isup_i)
               alpha_lock_o <= !alpha_lock_o;
         end else if (in_range) begin
            key_state_o[keycode_i] <= !isup_i;   // Held while down
         end
      end
   end

endmodule

/* source/keyboard_ctrl.sv */
module keyboard_ctrl (
   input  logic               clk,
   input  logic               reset_i,
   input  kbd_pkg::scancode_t recv_byte_i,
   input  logic               recv_trigger_i,
   output kbd_pkg::scancode_t map_code_o,
   output logic               map_ext_o,
   input  kbd_pkg::keycode_t  map_keycode_i,
   input  logic               map_valid_i,
   output logic               keypress_o,
   output kbd_pkg::keycode_t  keycode_o,
   output logic               isup_o
);

   localparam kbd_pkg::scancode_t EXT_PREFIX   = 8'hE0;
   localparam kbd_pkg::scancode_t BREAK_PREFIX = 8'hF0;

   kbd_pkg::kbd_state_e state_q;
   logic                in_break;
   logic                event_done;

   // Lookup runs on the byte as it arrives
   assign map_code_o = recv_byte_i;
   assign map_ext_o  = (state_q == kbd_pkg::EXT) || (state_q == kbd_pkg::EXT_BREAK);
   assign in_break   = (state_q == kbd_pkg::BREAK) || (state_q == kbd_pkg::EXT_BREAK);

   // A non-prefix byte that the table knows
   assign event_done = recv_trigger_i && map_valid_i &&
                       (recv_byte_i != EXT_PREFIX) && (recv_byte_i != BREAK_PREFIX);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= kbd_pkg::IDLE;
      end else if (recv_trigger_i) begin
         case (recv_byte_i)
            EXT_PREFIX: begin
               state_q <= kbd_pkg::EXT;
            end
            BREAK_PREFIX: begin
               // Keep the extended flag across the release prefix
               if (map_ext_o)
                  state_q <= kbd_pkg::EXT_BREAK;
               else
                  state_q <= kbd_pkg::BREAK;
            end
            default: begin
               state_q <= kbd_pkg::IDLE;   // Unmapped codes just end the sequence
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i)
         keypress_o <= 1'b0;
      else
         keypress_o <= event_done;   // One cycle strobe
   end

   always_ff @(posedge clk) begin
      if (event_done) begin
         keycode_o <= map_keycode_i;
         isup_o    <= in_break;
      end
   end

endmodule

/* source/scancode_map.sv */
`include "kbd_config.svh"

module scancode_map (
   input  kbd_pkg::scancode_t code_i,
   input  logic               ext_i,
   output kbd_pkg::keycode_t  keycode_o,
   output logic               valid_o
);

   // Set 2 make codes, extended flag in the top bit
   always_comb begin
      keycode_o = '0;
      valid_o   = 1'b1;
      case ({ext_i, code_i})
         // Letters A to Z
         9'h01C: keycode_o = 6'd0;
         9'h032: keycode_o = 6'd1;
         9'h021: keycode_o = 6'd2;
         9'h023: keycode_o = 6'd3;
         9'h024: keycode_o = 6'd4;
         9'h02B: keycode_o = 6'd5;
         9'h034: keycode_o = 6'd6;
         9'h033: keycode_o = 6'd7;
         9'h043: keycode_o = 6'd8;
         9'h03B: keycode_o = 6'd9;
         9'h042: keycode_o = 6'd10;
         9'h04B: keycode_o = 6'd11;
         9'h03A: keycode_o = 6'd12;
         9'h031: keycode_o = 6'd13;
         9'h044: keycode_o = 6'd14;
         9'h04D: keycode_o = 6'd15;
         9'h015: keycode_o = 6'd16;
         9'h02D: keycode_o = 6'd17;
         9'h01B: keycode_o = 6'd18;
         9'h02C: keycode_o = 6'd19;
         9'h03C: keycode_o = 6'd20;
         9'h02A: keycode_o = 6'd21;
         9'h01D: keycode_o = 6'd22;
         9'h022: keycode_o = 6'd23;
         9'h035: keycode_o = 6'd24;
         9'h01A: keycode_o = 6'd25;

         // Top row digits 0 to 9
         9'h045: keycode_o = 6'd26;
         9'h016: keycode_o = 6'd27;
         9'h01E: keycode_o = 6'd28;
         9'h026: keycode_o = 6'd29;
         9'h025: keycode_o = 6'd30;
         9'h02E: keycode_o = 6'd31;
         9'h036: keycode_o = 6'd32;
         9'h03D: keycode_o = 6'd33;
         9'h03E: keycode_o = 6'd34;
         9'h046: keycode_o = 6'd35;

         9'h029: keycode_o = 6'd36;   // Space
         9'h05A: keycode_o = 6'd37;   // Enter
         9'h055: keycode_o = 6'd38;   // Equals
         9'h04A: keycode_o = 6'd39;   // Slash
         9'h041: keycode_o = 6'd43;   // Comma
         9'h049: keycode_o = 6'd44;   // Period

         // Modifiers
         9'h012: keycode_o = 6'd40;   // Left shift
         9'h059: keycode_o = 6'd40;   // Right shift, same matrix key
         9'h014: keycode_o = 6'd41;   // Ctrl
         9'h011: keycode_o = 6'd42;   // Alt acts as fctn
         9'h058: keycode_o = kbd_pkg::keycode_t'(`KBD_ALPHA_CODE);

         // Arrow keys land on the E/S/D/X cluster
         9'h175: keycode_o = 6'd4;    // Up
         9'h16B: keycode_o = 6'd18;   // Left
         9'h174: keycode_o = 6'd3;    // Right
         9'h172: keycode_o = 6'd23;   // Down

         default: valid_o = 1'b0;
      endcase
   end

endmodule

/* source/ps2_receiver.sv */
`include "kbd_config.svh"

module ps2_receiver (
   input  logic               clk,
   input  logic               reset_i,
   input  logic               ps2_clk_i,
   input  logic               ps2_dat_i,
   output kbd_pkg::scancode_t recv_byte_o,
   output logic               recv_trigger_o,
   output logic               frame_err_o
);

   localparam int FILT_W = $clog2(`KBD_CLOCK_FILTER + 1);
   localparam int TMO_W  = $clog2(`KBD_FRAME_TIMEOUT + 1);

   logic [1:0]        clk_sync;
   logic [1:0]        dat_sync;
   logic              clk_filt;   // Debounced PS/2 clock level
   logic [FILT_W-1:0] filt_cnt;
   logic              edge_acc;
   logic              fall_acc;
   logic [3:0]        bit_cnt;
   logic [TMO_W-1:0]  tmo_cnt;
   logic [10:0]       shift_q;
   logic [10:0]       frame_next;
   logic              frame_ok;

   // New level has held long enough
   assign edge_acc = (clk_sync[1] != clk_filt) &&
                     (filt_cnt == FILT_W'(`KBD_CLOCK_FILTER - 1));
   assign fall_acc = edge_acc && clk_filt;

   // Bits arrive LSB first, start bit ends up in bit 0
   assign frame_next = {dat_sync[1], shift_q[10:1]};

   // Start low, stop high, odd parity over data and parity bit
   assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         clk_sync <= 2'b11;     // Bus idles high
         clk_filt <= 1'b1;
         filt_cnt <= '0;
      end else begin
         clk_sync <= {clk_sync[0], ps2_clk_i};
         if (clk_sync[1] == clk_filt) begin
            filt_cnt <= '0;
         end else if (edge_acc) begin
            clk_filt <= clk_sync[1];
            filt_cnt <= '0;
         end else begin
            filt_cnt <= filt_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      dat_sync <= {dat_sync[0], ps2_dat_i};
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         bit_cnt        <= '0;
         tmo_cnt        <= '0;
         recv_trigger_o <= 1'b0;
         frame_err_o    <= 1'b0;
      end else begin
         recv_trigger_o <= 1'b0;
         frame_err_o    <= 1'b0;
         if (fall_acc) begin
            tmo_cnt <= '0;
            if (bit_cnt == 4'd10) begin
               bit_cnt        <= '0;
               recv_trigger_o <= frame_ok;
               frame_err_o    <= !frame_ok;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else if (edge_acc) begin
            tmo_cnt <= '0;
         end else if (bit_cnt != 4'd0) begin
            // Keyboard went quiet mid frame
            if (tmo_cnt == TMO_W'(`KBD_FRAME_TIMEOUT - 1)) begin
               bit_cnt     <= '0;
               tmo_cnt     <= '0;
               frame_err_o <= 1'b1;
            end else begin
               tmo_cnt <= tmo_cnt + 1'b1;
            end
         end else begin
            tmo_cnt <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fall_acc) begin
         shift_q <= frame_next;
         if (bit_cnt == 4'd10)
            recv_byte_o <= frame_next[8:1];   // Data bits only
      end
   end

endmodule

/* source/kbd_pkg.sv */
`include "kbd_config.svh"

package kbd_pkg;

   // One byte as it arrives from the keyboard
   typedef logic [7:0] scancode_t;

   // Matrix position, 0 to 47
   typedef logic [0:5] keycode_t;

   // One bit per key, set while held
   typedef logic [0:`KBD_NUM_KEYS-1] key_state_t;

   // Prefix tracking
   typedef enum logic [1:0] {
      IDLE,      // No prefix seen
      EXT,       // After E0
      BREAK,     // After F0
      EXT_BREAK  // After E0 F0
   } kbd_state_e;

endpackage

/* source/kbd_config.svh */
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// Stable cycles before a new PS/2 clock level is taken
`define KBD_CLOCK_FILTER 8

// Idle cycles before a partial frame is thrown away
`define KBD_FRAME_TIMEOUT 2000

// Keys in the emulated matrix
`define KBD_NUM_KEYS 48

// Caps Lock slot, drives alpha lock only
`define KBD_ALPHA_CODE 47

`endif
